/* src.f */
+incdir+test
logic/ram_pkg.sv
logic/ram_write_port.sv
logic/ram_flops.sv
logic/ram_read_port.sv
logic/ram_integrity_monitor.sv
logic/ram_subsystem_top.sv
test/ram_tb.sv

/* run.sh */
#!/bin/sh
# Build the RAM subsystem testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module ram_tb -o ram_sim &&
./obj_dir/ram_sim || { echo "run.sh: build or simulation returned an error"; exit 1; }

/* test/ram_tb_checks.svh */
// Typed compare tasks and failure reporting for the RAM subsystem testbench
`ifndef RAM_TB_CHECKS_SVH
`define RAM_TB_CHECKS_SVH

task automatic report_failure(input string msg);
  $display("CHECK FAILED at %0t: %s", $time, msg);
  $display("Simulation failed");
  $fatal(1, "stopped at first error");
endtask

task automatic report_timeout();
  $display("Watchdog expired after %0d ns before the stimulus finished", WATCHDOG_NS);
  $display("Simulation failed");
  $fatal(1, "watchdog timeout");
endtask

task automatic check_resp(input rd_resp_t got, input rd_resp_t exp, input string what);
  if (got.valid !== exp.valid) begin
    report_failure($sformatf("%s valid %0b, expected %0b", what, got.valid, exp.valid));
  end else if (exp.valid && (got.addr !== exp.addr)) begin
    report_failure($sformatf("%s addr %0h, expected %0h", what, got.addr, exp.addr));
  end else if (exp.valid && (got.data !== exp.data)) begin
    report_failure($sformatf("%s data %08h at addr %0h, expected %08h",
                             what, got.data, exp.addr, exp.data));
  end
endtask

task automatic check_error(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    report_failure($sformatf("%s is %0b, expected %0b", what, got, exp));
  end
endtask

`endif

/* test/ram_tb.sv */
// Testbench for the flop RAM subsystem with reference model, response compare and watchdog
`timescale 1ns/1ps

module ram_tb;
  import ram_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 3;
  localparam int NUM_RANDOM      = 400;
  localparam int DRAIN_CYCLES    = 4;
  // Three sweeps plus the masked and clear section and the bypass section
  localparam int DIRECTED_CYCLES = 3 * DEPTH + 24 + 16;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + NUM_RANDOM + DRAIN_CYCLES + 1;
  localparam int WATCHDOG_NS     = (TOTAL_CYCLES + 50) * CLK_PERIOD;

  logic                  wr_clk;
  logic                  wr_rst;
  wr_cmd_t               wr_cmd;
  rd_req_t               rd_req;
  logic [ADDR_WIDTH-1:0] monitor_addr;
  rd_resp_t              rd_resp;
  logic                  integrity_error;

  logic [WIDTH-1:0] model_mem [DEPTH];
  rd_resp_t         exp_q [$];

  `include "ram_tb_checks.svh"

  ram_subsystem_top ram_subsystem_top_inst (
    .wr_clk          (wr_clk),
    .wr_rst          (wr_rst),
    .wr_cmd          (wr_cmd),
    .rd_req          (rd_req),
    .monitor_addr    (monitor_addr),
    .rd_resp         (rd_resp),
    .integrity_error (integrity_error)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(CLK_PERIOD / 2) wr_clk = ~wr_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    report_timeout();
  end

  // Full writes every word, masked only the enabled words, clear zeroes the entry
  function automatic void model_write(input wr_cmd_t cmd);
    for (int w = 0; w < NUM_WORDS; w++) begin
      if (cmd.op == OP_CLEAR) begin
        model_mem[cmd.addr][w*WORD_WIDTH +: WORD_WIDTH] = '0;
      end else if (cmd.op == OP_WRITE_FULL || cmd.word_en[w]) begin
        model_mem[cmd.addr][w*WORD_WIDTH +: WORD_WIDTH] = cmd.data[w*WORD_WIDTH +: WORD_WIDTH];
      end
    end
  endfunction

  function automatic rd_resp_t predict_read(input logic [ADDR_WIDTH-1:0] addr);
    rd_resp_t resp;
    resp.valid = 1'b1;
    resp.addr  = addr;
    resp.data  = model_mem[addr];
    return resp;
  endfunction

  function automatic wr_cmd_t make_write(input wr_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                                         input logic [WIDTH-1:0] data,
                                         input logic [NUM_WORDS-1:0] word_en);
    wr_cmd_t cmd;
    cmd = '{valid: 1'b1, op: op, addr: addr, data: data, word_en: word_en};
    return cmd;
  endfunction

  function automatic rd_req_t make_read(input logic [ADDR_WIDTH-1:0] addr);
    rd_req_t req;
    req = '{valid: 1'b1, addr: addr};
    return req;
  endfunction

  // Half of the picks land on the watched entry
  function automatic logic [ADDR_WIDTH-1:0] pick_addr();
    if ($urandom_range(1, 0) == 1) begin
      return monitor_addr;
    end
    return ADDR_WIDTH'($urandom_range(DEPTH - 1, 0));
  endfunction

  function automatic logic [NUM_WORDS-1:0] pick_word_en();
    return NUM_WORDS'($urandom_range((1 << NUM_WORDS) - 1, 1));
  endfunction

  // One cycle of stimulus with the read predicted after any write sampled at the same edge
  task automatic drive_cycle(input wr_cmd_t cmd, input rd_req_t req);
    @(negedge wr_clk);
    wr_cmd = cmd;
    rd_req = req;
    if (cmd.valid) begin
      model_write(cmd);
    end
    if (req.valid) begin
      exp_q.push_back(predict_read(req.addr));
    end else begin
      exp_q.push_back('0);
    end
  endtask

  // Outputs are compared 2 ns after each rising edge
  initial begin
    rd_resp_t exp;
    forever begin
      @(posedge wr_clk);
      #2;
      exp = '0;
      // Head entry was sampled at the edge before the one just passed
      if (exp_q.size() >= 2) begin
        exp = exp_q.pop_front();
      end
      check_resp(rd_resp, exp, "rd_resp");
      check_error(integrity_error, 1'b0, "integrity_error");
    end
  end

  initial begin
    wr_cmd_t cmd;
    rd_req_t req;
    logic [ADDR_WIDTH-1:0] a;
    void'($urandom(32'hd25c));
    wr_rst       = 1'b1;
    wr_cmd       = '0;
    rd_req       = '0;
    monitor_addr = ADDR_WIDTH'($urandom_range(DEPTH - 1, 0));
    for (int i = 0; i < DEPTH; i++) begin
      model_mem[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge wr_clk);
    wr_rst = 1'b0;

    // Untouched entries after reset read back one per cycle
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle('0, make_read(ADDR_WIDTH'(i)));
    end
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle(make_write(OP_WRITE_FULL, ADDR_WIDTH'(i), WIDTH'($urandom()), '0), '0);
    end
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle('0, make_read(ADDR_WIDTH'(i)));
    end

    // Masked writes on 0..7 and clears on 8..11
    for (int i = 0; i < 8; i++) begin
      drive_cycle(make_write(OP_WRITE_MASKED, ADDR_WIDTH'(i), WIDTH'($urandom()),
                             pick_word_en()), '0);
    end
    for (int i = 0; i < 8; i++) begin
      drive_cycle('0, make_read(ADDR_WIDTH'(i)));
    end
    for (int i = 8; i < 12; i++) begin
      drive_cycle(make_write(OP_CLEAR, ADDR_WIDTH'(i), WIDTH'($urandom()), '0), '0);
    end
    for (int i = 8; i < 12; i++) begin
      drive_cycle('0, make_read(ADDR_WIDTH'(i)));
    end

    // Bypass with a read and a write to one entry at the same edge
    for (int i = 0; i < 8; i++) begin
      a = pick_addr();
      cmd = make_write((i % 2 == 0) ? OP_WRITE_FULL : OP_WRITE_MASKED, a,
                       WIDTH'($urandom()), pick_word_en());
      drive_cycle(cmd, make_read(a));
    end
    // Read right behind a write
    for (int i = 0; i < 4; i++) begin
      a = pick_addr();
      drive_cycle(make_write(OP_WRITE_MASKED, a, WIDTH'($urandom()), pick_word_en()), '0);
      drive_cycle('0, make_read(a));
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      cmd = '0;
      req = '0;
      if ($urandom_range(1, 0) == 1) begin
        cmd = make_write(wr_op_e'(2'($urandom_range(2, 0))), pick_addr(),
                         WIDTH'($urandom()), pick_word_en());
      end
      if ($urandom_range(4, 0) < 3) begin
        req = make_read(pick_addr());
      end
      drive_cycle(cmd, req);
    end

    repeat (DRAIN_CYCLES) begin
      drive_cycle('0, '0);
    end
    @(negedge wr_clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* logic/ram_subsystem_top.sv */
// Top level of the flop RAM subsystem with write port, array, read port and integrity monitor
`timescale 1ns/1ps

module ram_subsystem_top (
  input  logic                           wr_clk,
  input  logic                           wr_rst,
  input  ram_pkg::wr_cmd_t               wr_cmd,
  input  ram_pkg::rd_req_t               rd_req,
  input  logic [ram_pkg::ADDR_WIDTH-1:0] monitor_addr,
  output ram_pkg::rd_resp_t              rd_resp,
  output logic                           integrity_error
);
  import ram_pkg::*;

  mem_wr_t          mem_wr;
  rd_req_t          rd_stage;
  logic [WIDTH-1:0] rd_word;

  ram_write_port ram_write_port_inst (
    .wr_clk (wr_clk),
    .wr_rst (wr_rst),
    .wr_cmd (wr_cmd),
    .mem_wr (mem_wr)
  );

  ram_flops ram_flops_inst (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .mem_wr   (mem_wr),
    .rd_stage (rd_stage),
    .rd_word  (rd_word)
  );

  ram_read_port ram_read_port_inst (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .rd_req   (rd_req),
    .rd_stage (rd_stage),
    .rd_word  (rd_word),
    .rd_resp  (rd_resp)
  );

  // Watches the same write and read traffic the array sees
  ram_integrity_monitor ram_integrity_monitor_inst (
    .wr_clk          (wr_clk),
    .wr_rst          (wr_rst),
    .monitor_addr    (monitor_addr),
    .mem_wr          (mem_wr),
    .rd_stage        (rd_stage),
    .rd_resp         (rd_resp),
    .integrity_error (integrity_error)
  );

endmodule

/* logic/ram_integrity_monitor.sv */
// Shadow model of one memory address that checks read responses and flags a sticky error
`timescale 1ns/1ps

module ram_integrity_monitor (
  input  logic                           wr_clk,
  input  logic                           wr_rst,
  input  logic [ram_pkg::ADDR_WIDTH-1:0] monitor_addr,
  input  ram_pkg::mem_wr_t               mem_wr,
  input  ram_pkg::rd_req_t               rd_stage,
  input  ram_pkg::rd_resp_t              rd_resp,
  output logic                           integrity_error
);
  import ram_pkg::*;

  logic                 wr_hit;
  logic                 rd_hit;
  logic                 wr_seen_q;
  logic [NUM_WORDS-1:0] written_q;
  logic [WIDTH-1:0]     shadow_q;

  logic [WIDTH-1:0]     exp_data;
  logic [NUM_WORDS-1:0] exp_known;
  logic                 exp_valid_q;
  logic [WIDTH-1:0]     exp_data_q;
  logic [NUM_WORDS-1:0] exp_known_q;
  logic [NUM_WORDS-1:0] word_diff;
  logic                 mismatch;

  assign wr_hit = mem_wr.valid && (mem_wr.addr == monitor_addr);
  assign rd_hit = rd_stage.valid && (rd_stage.addr == monitor_addr);

  // Shadow copy of the watched entry, updated at the same edge as the array
  always_ff @(posedge wr_clk) begin
    for (int w = 0; w < NUM_WORDS; w++) begin
      if (wr_hit && mem_wr.word_en[w]) begin
        shadow_q[w*WORD_WIDTH +: WORD_WIDTH] <= mem_wr.data[w*WORD_WIDTH +: WORD_WIDTH];
      end
    end
  end

  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      wr_seen_q <= 1'b0;
      written_q <= '0;
    end else begin
      if (mem_wr.valid) begin
        wr_seen_q <= 1'b1;
      end
      if (wr_hit) begin
        written_q <= written_q | mem_wr.word_en;
      end
    end
  end

  // Expected value seen by a read in rd_stage, pending write merged in
  always_comb begin
    for (int w = 0; w < NUM_WORDS; w++) begin
      if (wr_hit && mem_wr.word_en[w]) begin
        exp_data[w*WORD_WIDTH +: WORD_WIDTH]  = mem_wr.data[w*WORD_WIDTH +: WORD_WIDTH];
        exp_known[w]                          = 1'b1;
      end else begin
        // Unwritten words still hold the reset zero
        exp_data[w*WORD_WIDTH +: WORD_WIDTH]  = written_q[w] ?
                                                shadow_q[w*WORD_WIDTH +: WORD_WIDTH] : '0;
        exp_known[w]                          = written_q[w] || !wr_seen_q;
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (rd_hit) begin
      exp_data_q  <= exp_data;
      exp_known_q <= exp_known;
    end
  end

  always_comb begin
    for (int w = 0; w < NUM_WORDS; w++) begin
      word_diff[w] = rd_resp.data[w*WORD_WIDTH +: WORD_WIDTH] !=
                     exp_data_q[w*WORD_WIDTH +: WORD_WIDTH];
    end
  end

  assign mismatch = exp_valid_q && rd_resp.valid && (rd_resp.addr == monitor_addr) &&
                    |(word_diff & exp_known_q);

  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      exp_valid_q     <= 1'b0;
      integrity_error <= 1'b0;
    end else begin
      exp_valid_q <= rd_hit;
      // Sticky until the next reset
      if (mismatch) begin
        integrity_error <= 1'b1;
      end
    end
  end

  monitor_addr_stable_a: assert property (@(posedge wr_clk) disable iff (wr_rst)
    $stable(monitor_addr));

  no_integrity_error_a: assert property (@(posedge wr_clk) disable iff (wr_rst)
    !$rose(integrity_error));

endmodule

/* logic/ram_read_port.sv */
// Read port that stages requests and returns registered address-tagged responses
`timescale 1ns/1ps

module ram_read_port (
  input  logic                      wr_clk,
  input  logic                      wr_rst,
  input  ram_pkg::rd_req_t          rd_req,
  output ram_pkg::rd_req_t          rd_stage,
  input  logic [ram_pkg::WIDTH-1:0] rd_word,
  output ram_pkg::rd_resp_t         rd_resp
);
  import ram_pkg::*;

  logic                  stage_valid_q;
  logic [ADDR_WIDTH-1:0] stage_addr_q;
  logic                  resp_valid_q;
  logic [ADDR_WIDTH-1:0] resp_addr_q;
  logic [WIDTH-1:0]      resp_data_q;

  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      stage_valid_q <= 1'b0;
      resp_valid_q  <= 1'b0;
    end else begin
      stage_valid_q <= rd_req.valid;
      resp_valid_q  <= stage_valid_q;
    end
  end

  // Address and data follow their valid bits
  always_ff @(posedge wr_clk) begin
    if (rd_req.valid) begin
      stage_addr_q <= rd_req.addr;
    end
    if (stage_valid_q) begin
      resp_addr_q <= stage_addr_q;
      resp_data_q <= rd_word;
    end
  end

  assign rd_stage.valid = stage_valid_q;
  assign rd_stage.addr  = stage_addr_q;

  assign rd_resp.valid = resp_valid_q;
  assign rd_resp.addr  = resp_addr_q;
  assign rd_resp.data  = resp_data_q;

  // No stall, so every staged read comes back on the next cycle
  stage_to_resp_a: assert property (@(posedge wr_clk) disable iff (wr_rst)
    rd_stage.valid |=> rd_resp.valid);

endmodule

/* logic/ram_flops.sv */
// Flop-based memory array with reset clear, word-enabled writes and same-cycle read bypass
`timescale 1ns/1ps

module ram_flops (
  input  logic                         wr_clk,
  input  logic                         wr_rst,
  input  ram_pkg::mem_wr_t             mem_wr,
  input  ram_pkg::rd_req_t             rd_stage,
  output logic [ram_pkg::WIDTH-1:0]    rd_word
);
  import ram_pkg::*;

  logic [WIDTH-1:0] mem [DEPTH];
  logic             bypass_hit;

  // Storage, every entry comes out of reset as zero
  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_wr.valid) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        if (mem_wr.word_en[w]) begin
          mem[mem_wr.addr][w*WORD_WIDTH +: WORD_WIDTH] <=
            mem_wr.data[w*WORD_WIDTH +: WORD_WIDTH];
        end
      end
    end
  end

  assign bypass_hit = mem_wr.valid && (mem_wr.addr == rd_stage.addr);

  // Read path
  // A pending write to the same entry replaces its enabled words
  always_comb begin
    rd_word = mem[rd_stage.addr];
    if (bypass_hit) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        if (mem_wr.word_en[w]) begin
          rd_word[w*WORD_WIDTH +: WORD_WIDTH] = mem_wr.data[w*WORD_WIDTH +: WORD_WIDTH];
        end
      end
    end
  end

  // Reset clear plus decoded writes should never leave X in a read entry
  rd_word_known_a: assert property (@(posedge wr_clk) disable iff (wr_rst)
    rd_stage.valid |-> !$isunknown(rd_word));

endmodule

/* logic/ram_write_port.sv */
// Write port that turns opcode commands into registered word-enabled memory writes
`timescale 1ns/1ps

module ram_write_port (
  input  logic             wr_clk,
  input  logic             wr_rst,
  input  ram_pkg::wr_cmd_t wr_cmd,
  output ram_pkg::mem_wr_t mem_wr
);
  import ram_pkg::*;

  logic [WIDTH-1:0]      dec_data;
  logic [NUM_WORDS-1:0]  dec_word_en;

  logic                  wr_valid_q;
  logic [ADDR_WIDTH-1:0] wr_addr_q;
  logic [WIDTH-1:0]      wr_data_q;
  logic [NUM_WORDS-1:0]  wr_word_en_q;

  // Opcode decode
  always_comb begin
    dec_data    = wr_cmd.data;
    dec_word_en = '0;
    case (wr_cmd.op)
      OP_WRITE_FULL: begin
        dec_word_en = '1;
      end
      OP_WRITE_MASKED: begin
        dec_word_en = wr_cmd.word_en;
      end
      OP_CLEAR: begin
        dec_data    = '0;
        dec_word_en = '1;
      end
      // Unused encoding leaves every word untouched
      default: begin
        dec_word_en = '0;
      end
    endcase
  end

  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= wr_cmd.valid;
    end
  end

  // Payload only loads with a live command
  always_ff @(posedge wr_clk) begin
    if (wr_cmd.valid) begin
      wr_addr_q    <= wr_cmd.addr;
      wr_data_q    <= dec_data;
      wr_word_en_q <= dec_word_en;
    end
  end

  assign mem_wr.valid   = wr_valid_q;
  assign mem_wr.addr    = wr_addr_q;
  assign mem_wr.data    = wr_data_q;
  assign mem_wr.word_en = wr_word_en_q;

  // A masked write has to touch at least one word
  masked_write_has_enable_a: assert property (@(posedge wr_clk) disable iff (wr_rst)
    wr_cmd.valid && (wr_cmd.op == OP_WRITE_MASKED) |-> |wr_cmd.word_en);

endmodule

/* logic/ram_pkg.sv */
// Shared sizes, write opcodes and transfer structs for the flop RAM subsystem
package ram_pkg;

  // Array geometry
  localparam int DEPTH      = 16;
  localparam int ADDR_WIDTH = 4;
  localparam int WIDTH      = 32;
  localparam int WORD_WIDTH = 8;
  localparam int NUM_WORDS  = WIDTH / WORD_WIDTH;

  // Write command opcodes
  typedef enum logic [1:0] {
    OP_WRITE_FULL   = 2'd0,
    OP_WRITE_MASKED = 2'd1,
    OP_CLEAR        = 2'd2
  } wr_op_e;

  // External write command
  typedef struct packed {
    logic                  valid;
    wr_op_e                op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WIDTH-1:0]      data;
    logic [NUM_WORDS-1:0]  word_en;
  } wr_cmd_t;

  // Decoded memory write, enables already resolved from the opcode
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WIDTH-1:0]      data;
    logic [NUM_WORDS-1:0]  word_en;
  } mem_wr_t;

  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
  } rd_req_t;

  // Read response tagged with the address it came from
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WIDTH-1:0]      data;
  } rd_resp_t;

endpackage
